// ==== noc_consts.svh ====
//****************************************
// Router-wide constants for the 4x4 mesh
// Port count, VC depth, flit layout
//****************************************

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Local plus the four mesh directions
`define NOC_NUM_PORTS 5

// Single-flit VCs per input, also the credit limit per output
`define NOC_NUM_VC 4

// Flit width, destination id sits in the top bits
`define NOC_FLIT_W 16
`define NOC_ID_W 4

// Routers per mesh row
`define NOC_MESH_COLS 4

`endif

// ==== noc_pkg.sv ====
//****************************************
// Shared router types
// Flit, port vector, VC index, port names
//****************************************

`default_nettype none

`include "noc_consts.svh"

package noc_pkg;

    // Raw flit, destination id in the upper NOC_ID_W bits
    typedef logic [`NOC_FLIT_W-1:0] flit_t;

    // One bit per router port, one-hot for a route
    typedef logic [`NOC_NUM_PORTS-1:0] port_vec_t;

    // Selects one VC inside an input port
    typedef logic [$clog2(`NOC_NUM_VC)-1:0] vc_idx_t;

    // Port numbering, shared by routing and credit bit order
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_EAST  = 3'd4
    } port_e;

endpackage

`default_nettype wire

// ==== noc_sa_if.sv ====
//****************************************
// Switch-allocation handshake
// Input unit request, allocator grant
//****************************************

`default_nettype none

`include "noc_consts.svh"

interface noc_sa_if
    import noc_pkg::*;
();

    // Level request, held until granted
    logic      req;
    // Output port wanted by the offered VC, one-hot
    port_vec_t req_port;
    // Offered VC, consumed by the input unit when the grant lands
    vc_idx_t   req_vc;
    // Only high while req is high, accepted at the rising edge
    logic      gnt;

    modport requester (
        output req,
        output req_port,
        output req_vc,
        input  gnt
    );

    // Allocator only looks at the target port
    modport arbiter (
        input  req,
        input  req_port,
        output gnt
    );

endinterface

`default_nettype wire

// ==== route_compute.sv ====
//****************************************
// XY dimension-order route computation
//****************************************

`default_nettype none

`include "noc_consts.svh"

module route_compute
    import noc_pkg::*;
#(
    parameter int ROUTER_ID = 0
) (
    input  logic [`NOC_ID_W-1:0] dest_id,
    output port_vec_t            out_port
);

    // Own mesh position, fixed per router
    localparam logic [`NOC_ID_W-1:0] OWN_X = `NOC_ID_W'(ROUTER_ID % `NOC_MESH_COLS);
    localparam logic [`NOC_ID_W-1:0] OWN_Y = `NOC_ID_W'(ROUTER_ID / `NOC_MESH_COLS);

    logic [`NOC_ID_W-1:0] dest_x;
    logic [`NOC_ID_W-1:0] dest_y;

    assign dest_x = dest_id % `NOC_ID_W'(`NOC_MESH_COLS);
    assign dest_y = dest_id / `NOC_ID_W'(`NOC_MESH_COLS);

    // Resolve x first, then y, else eject
    always_comb begin
        if (dest_x > OWN_X) begin
            out_port = port_vec_t'(1) << PORT_EAST;
        end else if (dest_x < OWN_X) begin
            out_port = port_vec_t'(1) << PORT_WEST;
        end else if (dest_y > OWN_Y) begin
            // y grows toward south
            out_port = port_vec_t'(1) << PORT_SOUTH;
        end else if (dest_y < OWN_Y) begin
            out_port = port_vec_t'(1) << PORT_NORTH;
        end else begin
            out_port = port_vec_t'(1) << PORT_LOCAL;
        end
    end

endmodule

`default_nettype wire

// ==== input_unit.sv ====
//****************************************
// Input port with single-flit VC buffers
// Free-VC pick, routing, request, read
// Upstream credit return
//****************************************

`default_nettype none

`include "noc_consts.svh"

module input_unit
    import noc_pkg::*;
#(
    parameter int ROUTER_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  flit_t       in_flit,
    input  logic        in_valid,
    noc_sa_if.requester sa,
    output logic        rd_valid,
    output port_vec_t   rd_port,
    output flit_t       rd_flit,
    output logic        credit_out
);

    // VC storage, payload only
    flit_t                   vc_buf [`NOC_NUM_VC];
    logic [`NOC_NUM_VC-1:0]  vc_valid;
    // Route of every VC, valid only while the VC is occupied
    port_vec_t               vc_route [`NOC_NUM_VC];

    vc_idx_t                 wr_vc;
    vc_idx_t                 rd_vc;
    vc_idx_t                 req_vc;
    logic [`NOC_NUM_VC-1:0]  rd_mask;
    logic [`NOC_NUM_VC-1:0]  req_cand;

    // One route unit per VC
    for (genvar j = 0; j < `NOC_NUM_VC; j++) begin : g_rc
        route_compute #(
            .ROUTER_ID (ROUTER_ID)
        ) u_route_compute (
            .dest_id  (vc_buf[j][`NOC_FLIT_W-1 -: `NOC_ID_W]),
            .out_port (vc_route[j])
        );
    end

    // Lowest empty VC takes the next arrival
    always_comb begin
        wr_vc = '0;
        for (int j = `NOC_NUM_VC - 1; j >= 0; j--) begin
            if (!vc_valid[j]) begin
                wr_vc = vc_idx_t'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            vc_buf[wr_vc] <= in_flit;
        end
    end

    // Free on the edge after the grant, fill on arrival
    always_ff @(posedge clk) begin
        if (reset) begin
            vc_valid <= '0;
        end else begin
            if (rd_valid) begin
                vc_valid[rd_vc] <= 1'b0;
            end
            if (in_valid) begin
                vc_valid[wr_vc] <= 1'b1;
            end
        end
    end

    // VC under read must not be offered again
    assign rd_mask  = rd_valid ? (`NOC_NUM_VC'(1) << rd_vc) : '0;
    assign req_cand = vc_valid & ~rd_mask;

    // Lowest eligible VC wins the request slot
    always_comb begin
        req_vc = '0;
        for (int j = `NOC_NUM_VC - 1; j >= 0; j--) begin
            if (req_cand[j]) begin
                req_vc = vc_idx_t'(j);
            end
        end
    end

    assign sa.req      = |req_cand;
    assign sa.req_port = vc_route[req_vc];
    assign sa.req_vc   = req_vc;

    // Read stage, one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            credit_out <= 1'b0;
        end else begin
            rd_valid   <= sa.req & sa.gnt;
            // VC frees as the read retires
            credit_out <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sa.gnt) begin
            rd_vc   <= sa.req_vc;
            rd_port <= sa.req_port;
            rd_flit <= vc_buf[sa.req_vc];
        end
    end

    // Upstream sent with no credit left
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !(&vc_valid));

endmodule

`default_nettype wire

// ==== credit_tracker.sv ====
//****************************************
// Downstream free-VC counters
// One per non-local output
//****************************************

`default_nettype none

`include "noc_consts.svh"

module credit_tracker
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`NOC_NUM_PORTS-2:0] dwnstr_credit,
    input  port_vec_t                 grant_port,
    output logic [`NOC_NUM_PORTS-2:0] credit_ok
);

    // Counts 0 .. NOC_NUM_VC inclusive
    localparam int CW = $clog2(`NOC_NUM_VC + 1);

    logic [CW-1:0] cnt [`NOC_NUM_PORTS-1];

    // Bit i tracks output port i+1, local needs no credit
    for (genvar i = 0; i < `NOC_NUM_PORTS - 1; i++) begin : g_cnt
        logic spend;
        logic ret;

        assign spend = grant_port[i+1];
        assign ret   = dwnstr_credit[i];

        // Spend and return in one cycle cancel out
        always_ff @(posedge clk) begin
            if (reset) begin
                cnt[i] <= CW'(`NOC_NUM_VC);
            end else if (spend && !ret) begin
                cnt[i] <= cnt[i] - 1'b1;
            end else if (ret && !spend) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end

        assign credit_ok[i] = (cnt[i] != '0);

        // Downstream returned more than it was given
        a_no_over: assert property (@(posedge clk) disable iff (reset)
            !(cnt[i] == CW'(`NOC_NUM_VC) && ret && !spend));

        // Allocator granted with no credit
        a_no_under: assert property (@(posedge clk) disable iff (reset)
            !(cnt[i] == '0 && spend && !ret));
    end

endmodule

`default_nettype wire

// ==== switch_allocator.sv ====
//****************************************
// Round-robin switch allocator
// Per-output pointer, credit gated
//****************************************

`default_nettype none

`include "noc_consts.svh"

module switch_allocator
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    noc_sa_if.arbiter                 sa [`NOC_NUM_PORTS],
    input  logic [`NOC_NUM_PORTS-2:0] credit_ok,
    output port_vec_t                 grant_port
);

    localparam int NP = `NOC_NUM_PORTS;
    localparam int PW = $clog2(NP);

    logic      req      [NP];
    port_vec_t req_port [NP];
    // Per output, one bit per input
    port_vec_t out_req  [NP];
    port_vec_t out_gnt  [NP];
    // Per input, folded over outputs
    port_vec_t in_gnt;
    // Local output always accepts
    port_vec_t port_credit;

    assign port_credit = {credit_ok, 1'b1};

    // Flatten the interface array
    for (genvar i = 0; i < NP; i++) begin : g_in
        assign req[i]      = sa[i].req;
        assign req_port[i] = sa[i].req_port;
        assign sa[i].gnt   = in_gnt[i];
    end

    for (genvar o = 0; o < NP; o++) begin : g_out
        logic [PW-1:0] ptr;
        logic [PW-1:0] winner;
        logic          found;
        int            cand;
        port_vec_t     gnt_to;

        // Inputs aiming at this output
        always_comb begin
            for (int i = 0; i < NP; i++) begin
                out_req[o][i] = req[i] & req_port[i][o];
            end
        end

        // First requester at or after the pointer
        always_comb begin
            found  = 1'b0;
            winner = '0;
            cand   = 0;
            for (int k = 0; k < NP; k++) begin
                cand = int'(ptr) + k;
                if (cand >= NP) begin
                    cand = cand - NP;
                end
                if (!found && out_req[o][cand]) begin
                    found  = 1'b1;
                    winner = PW'(cand);
                end
            end
        end

        assign out_gnt[o]    = (found && port_credit[o]) ? (port_vec_t'(1) << winner) : '0;
        assign grant_port[o] = |out_gnt[o];

        // Pointer moves just past the winner
        always_ff @(posedge clk) begin
            if (reset) begin
                ptr <= '0;
            end else if (grant_port[o]) begin
                ptr <= (winner == PW'(NP - 1)) ? '0 : winner + 1'b1;
            end
        end

        // Granted inputs whose request points at this output
        always_comb begin
            for (int i = 0; i < NP; i++) begin
                gnt_to[i] = in_gnt[i] & req_port[i][o];
            end
        end

        a_out_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(gnt_to));
    end

    // Each input asks for one output, so at most one bit lands here
    always_comb begin
        in_gnt = '0;
        for (int o = 0; o < NP; o++) begin
            in_gnt = in_gnt | out_gnt[o];
        end
    end

endmodule

`default_nettype wire

// ==== crossbar.sv ====
//****************************************
// Registered 5x5 output crossbar
//****************************************

`default_nettype none

`include "noc_consts.svh"

module crossbar
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  port_vec_t rd_valid,
    input  port_vec_t rd_port  [`NOC_NUM_PORTS],
    input  flit_t     rd_flit  [`NOC_NUM_PORTS],
    output flit_t     out_flit [`NOC_NUM_PORTS],
    output port_vec_t out_valid
);

    for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : g_out
        port_vec_t hit;
        flit_t     sel_flit;

        // AND-OR mux, at most one hit per output
        always_comb begin
            sel_flit = '0;
            for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
                hit[i] = rd_valid[i] & rd_port[i][o];
                if (hit[i]) begin
                    sel_flit = sel_flit | rd_flit[i];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                out_valid[o] <= 1'b0;
            end else begin
                out_valid[o] <= |hit;
            end
        end

        always_ff @(posedge clk) begin
            out_flit[o] <= sel_flit;
        end

        // Allocator must never send two reads to one output
        a_one_source: assert property (@(posedge clk) disable iff (reset)
            $onehot0(hit));
    end

endmodule

`default_nettype wire

// ==== router_top.sv ====
//****************************************
// Virtual-channel mesh router top
// Input units, allocator, credits, crossbar
//****************************************

`default_nettype none

`include "noc_consts.svh"

module router_top
    import noc_pkg::*;
#(
    parameter int ROUTER_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  flit_t                     in_flit [`NOC_NUM_PORTS],
    input  port_vec_t                 in_valid,
    input  logic [`NOC_NUM_PORTS-2:0] dwnstr_credit,
    output logic [`NOC_NUM_PORTS-2:0] upstr_credit,
    output flit_t                     out_flit [`NOC_NUM_PORTS],
    output port_vec_t                 out_valid
);

    // Allocation handshake, one per input
    noc_sa_if sa_if [`NOC_NUM_PORTS] ();

    // Read stage to crossbar
    port_vec_t rd_valid;
    port_vec_t rd_port [`NOC_NUM_PORTS];
    flit_t     rd_flit [`NOC_NUM_PORTS];

    logic [`NOC_NUM_PORTS-2:0] credit_ok;
    port_vec_t                 grant_port;

    // Local injection has no upstream router to credit
    input_unit #(
        .ROUTER_ID (ROUTER_ID)
    ) u_input_local (
        .clk        (clk),
        .reset      (reset),
        .in_flit    (in_flit[PORT_LOCAL]),
        .in_valid   (in_valid[PORT_LOCAL]),
        .sa         (sa_if[PORT_LOCAL]),
        .rd_valid   (rd_valid[PORT_LOCAL]),
        .rd_port    (rd_port[PORT_LOCAL]),
        .rd_flit    (rd_flit[PORT_LOCAL]),
        .credit_out ()
    );

    // Mesh inputs, credit bit i-1 for port i
    for (genvar i = 1; i < `NOC_NUM_PORTS; i++) begin : g_in
        input_unit #(
            .ROUTER_ID (ROUTER_ID)
        ) u_input_unit (
            .clk        (clk),
            .reset      (reset),
            .in_flit    (in_flit[i]),
            .in_valid   (in_valid[i]),
            .sa         (sa_if[i]),
            .rd_valid   (rd_valid[i]),
            .rd_port    (rd_port[i]),
            .rd_flit    (rd_flit[i]),
            .credit_out (upstr_credit[i-1])
        );
    end

    switch_allocator u_switch_allocator (
        .clk        (clk),
        .reset      (reset),
        .sa         (sa_if),
        .credit_ok  (credit_ok),
        .grant_port (grant_port)
    );

    credit_tracker u_credit_tracker (
        .clk           (clk),
        .reset         (reset),
        .dwnstr_credit (dwnstr_credit),
        .grant_port    (grant_port),
        .credit_ok     (credit_ok)
    );

    crossbar u_crossbar (
        .clk       (clk),
        .reset     (reset),
        .rd_valid  (rd_valid),
        .rd_port   (rd_port),
        .rd_flit   (rd_flit),
        .out_flit  (out_flit),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== router_tb.sv ====
//****************************************
// Self-checking testbench for router_top
// Stimulus file reader, credit models
// Output scoreboard and closing report
//****************************************

`default_nettype none

`include "noc_consts.svh"

module router_tb
    import noc_pkg::*;
();

    localparam int NP             = `NOC_NUM_PORTS;
    localparam int MAX_ENT        = 64;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int OUT_TIMEOUT    = 500;
    localparam int QUIET_CYCLES   = 40;
    localparam int DRAIN_CYCLES   = 10;

    logic                      clk;
    logic                      reset;
    flit_t                     in_flit  [NP];
    port_vec_t                 in_valid;
    logic [`NOC_NUM_PORTS-2:0] dwnstr_credit = '0;
    logic [`NOC_NUM_PORTS-2:0] upstr_credit;
    flit_t                     out_flit [NP];
    port_vec_t                 out_valid;

    // Stimulus table, one row per flit
    int    ent_phase [MAX_ENT];
    int    ent_port  [MAX_ENT];
    flit_t ent_flit  [MAX_ENT];
    int    ent_exp   [MAX_ENT];
    bit    injected  [MAX_ENT];
    bit    seen      [MAX_ENT];
    int    num_ent;
    int    phase_total [4];
    int    phase_seen  [4];

    // Upstream side, free VCs of each DUT input = NOC_NUM_VC - sent + returned
    int    sent     [NP];
    int    returned [NP];

    // Downstream side, credit return delay line per output
    logic [2:0] credit_dly [NP];
    bit         hold_east;
    int         held_east;
    int         east3_cnt;

    int    out_cnt;
    int    mismatch_cnt;
    int    fail_cnt;

    router_top #(
        .ROUTER_ID (5)
    ) u_router_top (
        .clk           (clk),
        .reset         (reset),
        .in_flit       (in_flit),
        .in_valid      (in_valid),
        .dwnstr_credit (dwnstr_credit),
        .upstr_credit  (upstr_credit),
        .out_flit      (out_flit),
        .out_valid     (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp_val, act_val);
            mismatch_cnt++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        fail_cnt++;
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        report_failure(msg);
        finish_run();
    endtask

    function automatic int credits_left(input int p);
        return `NOC_NUM_VC - sent[p] + returned[p];
    endfunction

    // Rows are phase, input port, flit in hex, expected output port
    task automatic load_stimulus();
        int    fd;
        int    code;
        int    ph;
        int    pt;
        int    fl;
        int    ex;
        string line;
        fd = $fopen("router_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open router_stimulus.txt");
        end else begin
            while (!$feof(fd) && num_ent < MAX_ENT) begin
                code = $fgets(line, fd);
                // Comment and blank lines do not parse as four fields
                if (code != 0 && $sscanf(line, "%d %d %h %d", ph, pt, fl, ex) == 4) begin
                    if (ph < 1 || ph > 3) begin
                        report_failure($sformatf("bad phase %0d in stimulus file", ph));
                    end else begin
                        ent_phase[num_ent] = ph;
                        ent_port[num_ent]  = pt;
                        ent_flit[num_ent]  = flit_t'(fl);
                        ent_exp[num_ent]   = ex;
                        phase_total[ph]++;
                        num_ent++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Burst mode packs rows on distinct ports into one cycle
    // Otherwise one flit per send with a random gap
    task automatic inject_phase(input int ph, input bit burst);
        int        i;
        int        p;
        int        stall;
        int        gap;
        port_vec_t used;
        i     = 0;
        stall = 0;
        gap   = 0;
        // Rows are grouped by phase in the file
        while (i < num_ent && ent_phase[i] != ph) begin
            i++;
        end
        while (i < num_ent && ent_phase[i] == ph) begin
            @(negedge clk);
            in_valid = '0;
            used     = '0;
            if (gap > 0) begin
                gap--;
            end else begin
                while (i < num_ent && ent_phase[i] == ph && !used[ent_port[i]] &&
                       credits_left(ent_port[i]) > 0 && (burst || used == '0)) begin
                    p           = ent_port[i];
                    in_flit[p]  = ent_flit[i];
                    in_valid[p] = 1'b1;
                    used[p]     = 1'b1;
                    sent[p]++;
                    injected[i] = 1'b1;
                    i++;
                end
                if (used == '0) begin
                    // Blocked on upstream credit
                    stall++;
                    if (stall > CREDIT_TIMEOUT) begin
                        abort_run($sformatf("no upstream credit on port %0d", ent_port[i]));
                    end
                end else begin
                    stall = 0;
                    if (!burst) begin
                        gap = int'($urandom % 4);
                    end
                end
            end
        end
        @(negedge clk);
        in_valid = '0;
    endtask

    task automatic wait_phase_out(input int ph);
        int cnt;
        cnt = 0;
        while (phase_seen[ph] < phase_total[ph] && cnt < OUT_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (phase_seen[ph] < phase_total[ph]) begin
            abort_run($sformatf("phase %0d flits did not all come out, %0d of %0d",
                                ph, phase_seen[ph], phase_total[ph]));
        end
    endtask

    task automatic wait_east_count(input int want);
        int cnt;
        cnt = 0;
        while (east3_cnt < want && cnt < OUT_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (east3_cnt < want) begin
            abort_run("east output sent fewer flits than its credits allow");
        end
    endtask

    // Match an output flit against injected rows not yet seen
    task automatic record_output(input int o, input flit_t val);
        int k;
        int hit;
        bit dup;
        hit = -1;
        dup = 1'b0;
        out_cnt++;
        for (k = 0; k < num_ent; k++) begin
            if (injected[k] && ent_flit[k] == val) begin
                if (seen[k]) begin
                    dup = 1'b1;
                end else if (hit < 0) begin
                    hit = k;
                end
            end
        end
        if (hit >= 0) begin
            seen[hit] = 1'b1;
            phase_seen[ent_phase[hit]]++;
            check_value($sformatf("route_p%0d_flit_%h", ent_phase[hit], val), ent_exp[hit], o);
            // Local input has no credit wire, a departure frees its VC
            if (ent_port[hit] == PORT_LOCAL) begin
                returned[PORT_LOCAL]++;
            end
            if (o == PORT_EAST && ent_phase[hit] == 3) begin
                east3_cnt++;
            end
        end else if (dup) begin
            report_failure($sformatf("flit %h came out a second time on port %0d", val, o));
        end else begin
            report_failure($sformatf("unknown flit %h on output port %0d", val, o));
        end
    endtask

    // Output monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int o = 0; o < NP; o++) begin
                if (out_valid[o]) begin
                    record_output(o, out_flit[o]);
                end
            end
            for (int p = 1; p < NP; p++) begin
                if (upstr_credit[p-1]) begin
                    returned[p]++;
                end
            end
        end
    end

    // Downstream routers, credit back three cycles after each departure
    always @(negedge clk) begin
        if (reset) begin
            dwnstr_credit = '0;
            held_east     = 0;
            for (int o = 0; o < NP; o++) begin
                credit_dly[o] = '0;
            end
        end else begin
            for (int o = 1; o < NP; o++) begin
                if (out_valid[o] && o == PORT_EAST && hold_east) begin
                    held_east++;
                    credit_dly[o] = {credit_dly[o][1:0], 1'b0};
                end else begin
                    credit_dly[o] = {credit_dly[o][1:0], out_valid[o]};
                end
                dwnstr_credit[o-1] = credit_dly[o][2];
            end
            // Withheld east credits trickle back once released
            if (!hold_east && held_east > 0 && !dwnstr_credit[PORT_EAST-1]) begin
                dwnstr_credit[PORT_EAST-1] = 1'b1;
                held_east--;
            end
        end
    end

    initial begin
        void'($urandom(83));
        reset     = 1'b1;
        in_valid  = '0;
        hold_east = 1'b0;
        for (int p = 0; p < NP; p++) begin
            in_flit[p] = '0;
        end
        load_stimulus();

        // Outputs quiet while reset is held
        repeat (2) begin
            @(negedge clk);
            check_value("reset_out_valid", 0, 32'(out_valid));
            check_value("reset_upstr_credit", 0, 32'(upstr_credit));
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("post_reset_out_valid", 0, 32'(out_valid));
        check_value("post_reset_upstr_credit", 0, 32'(upstr_credit));

        // XY routing, spaced flits
        inject_phase(1, 1'b0);
        wait_phase_out(1);

        // Several inputs hit one output in the same cycle
        inject_phase(2, 1'b1);
        wait_phase_out(2);
        repeat (DRAIN_CYCLES) @(negedge clk);

        // East downstream stops returning credits
        @(posedge clk);
        hold_east = 1'b1;
        inject_phase(3, 1'b1);
        wait_east_count(`NOC_NUM_VC);
        repeat (QUIET_CYCLES) @(negedge clk);
        check_value("east_backpressure", `NOC_NUM_VC, east3_cnt);
        @(posedge clk);
        hold_east = 1'b0;
        wait_phase_out(3);

        repeat (QUIET_CYCLES) @(negedge clk);
        for (int p = 1; p < NP; p++) begin
            check_value($sformatf("upstream_credit_port%0d", p), sent[p], returned[p]);
        end
        check_value("total_flits_out", num_ent, out_cnt);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== router_stimulus.txt ====
# phase input_port flit_hex expected_output_port
# ports 0 local 1 north 2 south 3 west 4 east, router id 5 at x 1 y 1
1 0 6001 4
1 0 4002 3
1 0 1003 1
1 0 9004 2
1 1 5005 0
1 1 d006 2
1 1 7007 4
1 2 1008 1
1 2 0009 3
1 2 500a 0
1 3 200b 4
1 3 500c 0
1 3 d00d 2
1 4 800e 3
1 4 100f 1
1 4 5010 0
2 0 f101 4
2 1 b102 4
2 2 3103 4
2 3 e104 4
2 1 5105 0
2 2 5106 0
2 3 5107 0
2 4 5108 0
2 1 410a 3
2 2 810b 3
2 4 010c 3
2 0 c109 3
3 0 6201 4
3 1 7202 4
3 2 a203 4
3 3 b204 4
3 0 f205 4
3 1 2206 4
3 3 3207 4

// ==== mesh_router.f ====
+incdir+.
noc_pkg.sv
noc_sa_if.sv
route_compute.sv
input_unit.sv
credit_tracker.sv
switch_allocator.sv
crossbar.sv
router_top.sv
router_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module router_tb -f mesh_router.f

run: build
	@out=$$(./obj_dir/Vrouter_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q '^Simulation passed$$'

lint:
	verilator --lint-only -Wall --timing --assert \
		--top-module router_top -f mesh_router.f

clean:
	rm -rf obj_dir
